/* verilog/sobel_params.svh */
`ifndef SOBEL_PARAMS_SVH
`define SOBEL_PARAMS_SVH

// pixels per video line
// sets the row memory depth and the column counter range, minimum 3
`define SOBEL_LINE_WIDTH 16

// greyscale pixel width
// the kernel arithmetic is sized for 8-bit pixels
`define SOBEL_PIX_BITS 8

`endif

/* verilog/sobel_pkg.sv */
`include "sobel_params.svh"

package sobel_pkg;

	// one unsigned greyscale pixel
	typedef logic [`SOBEL_PIX_BITS-1:0] pixel_t;

	// squared gradient magnitude, gx^2 + gy^2
	// each square fits in 21 bits, so the sum fits in 22
	typedef logic [21:0] mag_t;

	// window scan state
	typedef enum logic [1:0] {
		SCAN_IDLE = 2'd0,
		SCAN_FILL = 2'd1,
		SCAN_RUN  = 2'd2
	} scan_state_t;

endpackage

/* verilog/sobel_line_buffer.sv */
`include "sobel_params.svh"

module sobel_line_buffer
	import sobel_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rstn,

	input  pixel_t i_pix,
	input  logic   i_valid,
	input  logic   i_sof,

	// pixels one and two rows above the current column
	output pixel_t o_up1,
	output pixel_t o_up2
);

	localparam int WIDTH = `SOBEL_LINE_WIDTH;
	localparam int COL_W = $clog2(WIDTH);
	localparam logic [COL_W-1:0] LAST_COL = COL_W'(WIDTH - 1);

	// row 1 holds the previous line, row 2 the line before it
	pixel_t row1_mem [WIDTH];
	pixel_t row2_mem [WIDTH];

	logic             sof_pix;
	logic [COL_W-1:0] wr_col;
	logic [COL_W-1:0] col;

	assign sof_pix = i_valid & i_sof;

	// start of frame forces column 0 for this pixel
	assign col = sof_pix ? '0 : wr_col;

	// combinational reads, available in the same cycle as the pixel
	assign o_up1 = row1_mem[col];
	assign o_up2 = row2_mem[col];

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			wr_col <= '0;
		end else if (i_valid) begin
			if (col == LAST_COL) begin
				wr_col <= '0;
			end else begin
				wr_col <= col + 1'b1;
			end
		end
	end

	// age the column by one row and store the new pixel
	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			row2_mem[col] <= row1_mem[col];
			row1_mem[col] <= i_pix;
		end
	end

endmodule

/* verilog/sobel_window.sv */
`include "sobel_params.svh"

module sobel_window
	import sobel_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rstn,

	input  pixel_t      i_pix,
	input  pixel_t      i_up1,
	input  pixel_t      i_up2,
	input  logic        i_valid,
	input  logic        i_sof,

	// three pixels per row, oldest column in the high byte
	output logic [23:0] o_r0_data,
	output logic [23:0] o_r1_data,
	output logic [23:0] o_r2_data,
	output logic        o_valid
);

	localparam int WIDTH = `SOBEL_LINE_WIDTH;
	localparam int COL_W = $clog2(WIDTH);
	localparam logic [COL_W-1:0] LAST_COL = COL_W'(WIDTH - 1);

	scan_state_t      state_q;
	scan_state_t      state_d;
	logic [COL_W-1:0] col_q;
	logic [1:0]       row_q;

	logic             sof_pix;
	logic             accept;
	logic [COL_W-1:0] cur_col;
	logic [1:0]       cur_row;
	logic             col_wrap;
	logic [1:0]       row_d;

	assign sof_pix = i_valid & i_sof;

	// nothing is taken before the first start of frame
	assign accept = sof_pix | (i_valid & (state_q != SCAN_IDLE));

	assign cur_col  = sof_pix ? '0 : col_q;
	assign cur_row  = sof_pix ? 2'd0 : row_q;
	assign col_wrap = (cur_col == LAST_COL);

	// row count saturates at 2, only the first two rows matter
	assign row_d = (col_wrap && cur_row != 2'd2) ? cur_row + 2'd1 : cur_row;

	always_comb begin
		state_d = state_q;
		case (state_q)
			SCAN_IDLE: if (sof_pix) state_d = SCAN_FILL;
			SCAN_FILL: if (accept && row_d == 2'd2) state_d = SCAN_RUN;
			SCAN_RUN:  if (sof_pix) state_d = SCAN_FILL;
			default:   state_d = SCAN_IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			state_q <= SCAN_IDLE;
			col_q   <= '0;
			row_q   <= 2'd0;
			o_valid <= 1'b0;
		end else begin
			state_q <= state_d;
			o_valid <= accept && (state_q == SCAN_RUN) && (cur_col >= COL_W'(2));
			if (accept) begin
				col_q <= col_wrap ? '0 : cur_col + 1'b1;
				row_q <= row_d;
			end
		end
	end

	// shift the new column in on the right
	always_ff @(posedge i_clk) begin
		if (accept) begin
			o_r0_data <= {o_r0_data[15:0], i_up2};
			o_r1_data <= {o_r1_data[15:0], i_up1};
			o_r2_data <= {o_r2_data[15:0], i_pix};
		end
	end

endmodule

/* verilog/ps_sobel.sv */
module ps_sobel
	import sobel_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rstn,

	// 3x3 window, top row on r0, oldest column in the high byte
	input  logic [23:0] i_r0_data,
	input  logic [23:0] i_r1_data,
	input  logic [23:0] i_r2_data,
	input  logic        i_valid,

	input  mag_t        i_threshold,

	output pixel_t      o_data,
	output logic        o_valid
);

	localparam int PB = $bits(pixel_t);

	localparam pixel_t EDGE_PIX = 8'hFF;
	localparam pixel_t FLAT_PIX = 8'h00;

	// raster order within the window, index = row * 3 + column
	// horizontal: right column minus left, centre row weighted 2
	localparam logic signed [10:0] COEF_X [9] = '{
		-11'sd1, 11'sd0, 11'sd1,
		-11'sd2, 11'sd0, 11'sd2,
		-11'sd1, 11'sd0, 11'sd1
	};
	// vertical: top row minus bottom, centre column weighted 2
	localparam logic signed [10:0] COEF_Y [9] = '{
		11'sd1, 11'sd2, 11'sd1,
		11'sd0, 11'sd0, 11'sd0,
		-11'sd1, -11'sd2, -11'sd1
	};

	logic [23:0] rows [3];
	pixel_t      pix [9];

	// stage 1 multiply, stage 2 extra register
	logic signed [10:0] mul_x_q [9];
	logic signed [10:0] mul_y_q [9];
	logic               mul_valid_q;
	logic signed [10:0] prod_x_q [9];
	logic signed [10:0] prod_y_q [9];
	logic               prod_valid_q;

	// stage 3 accumulate
	logic signed [10:0] acc_x;
	logic signed [10:0] acc_y;
	logic signed [10:0] sum_x_q;
	logic signed [10:0] sum_y_q;
	logic               sum_valid_q;

	// stage 4 square
	logic [20:0]        sq_x_q;
	logic [20:0]        sq_y_q;
	logic               sq_valid_q;
	mag_t               mag;

	assign rows[0] = i_r0_data;
	assign rows[1] = i_r1_data;
	assign rows[2] = i_r2_data;

	always_comb begin
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				pix[r*3+c] = rows[r][(2-c)*PB +: PB];
			end
		end
	end

	always_ff @(posedge i_clk) begin
		for (int k = 0; k < 9; k++) begin
			mul_x_q[k]  <= COEF_X[k] * $signed({3'b000, pix[k]});
			mul_y_q[k]  <= COEF_Y[k] * $signed({3'b000, pix[k]});
			prod_x_q[k] <= mul_x_q[k];
			prod_y_q[k] <= mul_y_q[k];
		end
	end

	// both sums start from zero, range fits 11 bits signed
	always_comb begin
		acc_x = '0;
		acc_y = '0;
		for (int k = 0; k < 9; k++) begin
			acc_x = acc_x + prod_x_q[k];
			acc_y = acc_y + prod_y_q[k];
		end
	end

	always_ff @(posedge i_clk) begin
		sum_x_q <= acc_x;
		sum_y_q <= acc_y;
		sq_x_q  <= sum_x_q * sum_x_q;
		sq_y_q  <= sum_y_q * sum_y_q;
	end

	assign mag = sq_x_q + sq_y_q;

	always_ff @(posedge i_clk) begin
		o_data <= (mag > i_threshold) ? EDGE_PIX : FLAT_PIX;
	end

	// valid follows the data through all five stages
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			mul_valid_q  <= 1'b0;
			prod_valid_q <= 1'b0;
			sum_valid_q  <= 1'b0;
			sq_valid_q   <= 1'b0;
			o_valid      <= 1'b0;
		end else begin
			mul_valid_q  <= i_valid;
			prod_valid_q <= mul_valid_q;
			sum_valid_q  <= prod_valid_q;
			sq_valid_q   <= sum_valid_q;
			o_valid      <= sq_valid_q;
		end
	end

endmodule

/* verilog/sobel_edge_top.sv */
module sobel_edge_top
	import sobel_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rstn,

	input  pixel_t i_pix,
	input  logic   i_valid,
	input  logic   i_sof,
	input  mag_t   i_threshold,

	// 8'hFF on an edge, 8'h00 otherwise
	output pixel_t o_edge,
	output logic   o_valid
);

	pixel_t      up1;
	pixel_t      up2;
	logic [23:0] win_r0;
	logic [23:0] win_r1;
	logic [23:0] win_r2;
	logic        win_valid;

	sobel_line_buffer u_line_buffer (
		.i_clk   (i_clk),
		.i_rstn  (i_rstn),
		.i_pix   (i_pix),
		.i_valid (i_valid),
		.i_sof   (i_sof),
		.o_up1   (up1),
		.o_up2   (up2)
	);

	// one cycle from pixel to window
	sobel_window u_window (
		.i_clk     (i_clk),
		.i_rstn    (i_rstn),
		.i_pix     (i_pix),
		.i_up1     (up1),
		.i_up2     (up2),
		.i_valid   (i_valid),
		.i_sof     (i_sof),
		.o_r0_data (win_r0),
		.o_r1_data (win_r1),
		.o_r2_data (win_r2),
		.o_valid   (win_valid)
	);

	// five more cycles through the kernel
	ps_sobel u_kernel (
		.i_clk       (i_clk),
		.i_rstn      (i_rstn),
		.i_r0_data   (win_r0),
		.i_r1_data   (win_r1),
		.i_r2_data   (win_r2),
		.i_valid     (win_valid),
		.i_threshold (i_threshold),
		.o_data      (o_edge),
		.o_valid     (o_valid)
	);

endmodule

/* bench/sobel_clk_gen.sv */
module sobel_clk_gen (
	output logic o_clk,
	output logic o_rstn
);

	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 2;

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// reset low over two rising edges, released on a falling edge
	initial begin
		o_rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rstn = 1'b1;
	end

endmodule

/* bench/tb_sobel_edge.sv */
`include "sobel_params.svh"

module tb_sobel_edge
	import sobel_pkg::*;
();

	localparam int W           = `SOBEL_LINE_WIDTH;
	localparam int MAX_ROWS    = 9;
	localparam int FRAME_ROWS  = 8;
	localparam int PRE_SOF_PIX = 40;
	localparam int LATENCY     = 6;
	localparam int B2B_FRAMES  = 5;
	localparam int B2B_ROWS [B2B_FRAMES] = '{5, 3, 9, 2, 6};
	// five single frames plus the back-to-back group
	localparam int TOTAL_PIX = PRE_SOF_PIX + 5 * FRAME_ROWS * W + (5 + 3 + 9 + 2 + 6) * W;
	localparam int TIMEOUT_CYCLES = TOTAL_PIX * 4 + 100;

	logic        clk;
	logic        rstn;
	pixel_t      pix;
	logic        valid;
	logic        sof;
	mag_t        threshold;
	pixel_t      edge_pix;
	logic        out_valid;

	logic [31:0] lfsr_state;
	pixel_t      frame [W*MAX_ROWS];
	pixel_t      exp_q [$];
	int          out_count;
	int          pending_count;
	string       test_name;

	sobel_clk_gen u_clk_gen (
		.o_clk  (clk),
		.o_rstn (rstn)
	);

	sobel_edge_top i_dut (
		.i_clk       (clk),
		.i_rstn      (rstn),
		.i_pix       (pix),
		.i_valid     (valid),
		.i_sof       (sof),
		.i_threshold (threshold),
		.o_edge      (edge_pix),
		.o_valid     (out_valid)
	);

	function automatic logic lfsr_step();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b) begin
			lfsr_state = lfsr_state ^ 32'hA300_0000;
		end
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_step()};
		end
		return v;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic compare_edge(input pixel_t exp, input pixel_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s: expected 8'h%02h, actual 8'h%02h", test_name, exp, act));
		end
	endtask

	task automatic compare_count(input int exp, input int act);
		if (act != exp) begin
			abort_run($sformatf("ERR %s: expected %0d outputs, actual %0d", test_name, exp, act));
		end
	endtask

	// reference Sobel for the window whose bottom right pixel is (r, c)
	function automatic pixel_t model_edge(input int r, input int c, input mag_t thr);
		int   gx;
		int   gy;
		int   wt;
		mag_t mag;
		gx = 0;
		gy = 0;
		for (int k = 0; k < 3; k++) begin
			wt = (k == 1) ? 2 : 1;
			gx += wt * (int'(frame[(r-2+k)*W + c]) - int'(frame[(r-2+k)*W + c-2]));
			gy += wt * (int'(frame[(r-2)*W + c-2+k]) - int'(frame[r*W + c-2+k]));
		end
		mag = mag_t'(gx * gx + gy * gy);
		return (mag > thr) ? 8'hFF : 8'h00;
	endfunction

	task automatic fill_random(input int rows);
		for (int i = 0; i < rows * W; i++) begin
			frame[i] = pixel_t'(rand_bits(8));
		end
	endtask

	task automatic fill_flat(input int rows, input pixel_t v);
		for (int i = 0; i < rows * W; i++) begin
			frame[i] = v;
		end
	endtask

	task automatic start_test(input string name);
		scan_state_t st;
		test_name = name;
		st = i_dut.u_window.state_q;
		$display("%s: window in %s", name, st.name());
	endtask

	task automatic set_threshold(input mag_t t);
		@(negedge clk);
		threshold = t;
	endtask

	task automatic send_frame(input int rows, input bit gaps, input bit check_prev);
		int prev_count;
		int n;
		prev_count = pending_count;
		for (int r = 2; r < rows; r++) begin
			for (int c = 2; c < W; c++) begin
				exp_q.push_back(model_edge(r, c, threshold));
			end
		end
		pending_count = (W - 2) * (rows - 2);
		for (int p = 0; p < rows * W; p++) begin
			// by the end of row 0 the last frame has drained and this one has no result yet
			if (check_prev && p == W) begin
				compare_count(prev_count, out_count);
				out_count = 0;
			end
			if (gaps) begin
				n = int'(rand_bits(2));
				repeat (n) begin
					@(negedge clk);
					valid = 1'b0;
					sof = 1'b0;
				end
			end
			@(negedge clk);
			pix = frame[p];
			valid = 1'b1;
			sof = (p == 0);
		end
	endtask

	task automatic finish_frame();
		@(negedge clk);
		valid = 1'b0;
		sof = 1'b0;
		// the last result leaves the pipeline LATENCY cycles after the last pixel
		// the extra cycles leave room for a stray result to show up
		repeat (LATENCY + 8) @(negedge clk);
		compare_count(pending_count, out_count);
		out_count = 0;
		pending_count = 0;
	endtask

	always @(posedge clk) begin
		if (rstn && out_valid) begin
			if (exp_q.size() == 0) begin
				abort_run($sformatf("%s: output 8'h%02h arrived with no result expected",
					test_name, edge_pix));
			end else begin
				compare_edge(exp_q.pop_front(), edge_pix);
				out_count++;
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, results stopped coming out", TIMEOUT_CYCLES);
		$display("Test failures found");
		$fatal(1);
	end

	initial begin
		pix = '0;
		valid = 1'b0;
		sof = 1'b0;
		threshold = '0;
		lfsr_state = 32'h487;
		out_count = 0;
		pending_count = 0;
		test_name = "reset";
		while (rstn !== 1'b1) @(negedge clk);

		start_test("pre_sof");
		for (int i = 0; i < PRE_SOF_PIX; i++) begin
			@(negedge clk);
			pix = pixel_t'(rand_bits(8));
			valid = 1'b1;
			sof = 1'b0;
		end
		finish_frame();

		start_test("random_frame");
		set_threshold(mag_t'(rand_bits(17)));
		fill_random(FRAME_ROWS);
		send_frame(FRAME_ROWS, 1'b0, 1'b0);
		finish_frame();

		start_test("flat_frame");
		set_threshold('0);
		fill_flat(FRAME_ROWS, pixel_t'(rand_bits(8)));
		send_frame(FRAME_ROWS, 1'b0, 1'b0);
		finish_frame();

		// same frame at both ends of the threshold range
		start_test("threshold_zero");
		fill_random(FRAME_ROWS);
		set_threshold('0);
		send_frame(FRAME_ROWS, 1'b0, 1'b0);
		finish_frame();
		start_test("threshold_max");
		set_threshold('1);
		send_frame(FRAME_ROWS, 1'b0, 1'b0);
		finish_frame();

		start_test("valid_gaps");
		set_threshold(mag_t'(rand_bits(17)));
		fill_random(FRAME_ROWS);
		send_frame(FRAME_ROWS, 1'b1, 1'b0);
		finish_frame();

		start_test("back_to_back");
		set_threshold(mag_t'(rand_bits(17)));
		for (int k = 0; k < B2B_FRAMES; k++) begin
			fill_random(B2B_ROWS[k]);
			send_frame(B2B_ROWS[k], 1'b0, k > 0);
		end
		finish_frame();

		$display("All tests passed!");
		$finish;
	end

endmodule

/* sobel_edge_top.f */
+incdir+verilog
verilog/sobel_pkg.sv
verilog/sobel_line_buffer.sv
verilog/sobel_window.sv
verilog/ps_sobel.sv
verilog/sobel_edge_top.sv
bench/sobel_clk_gen.sv
bench/tb_sobel_edge.sv

/* Makefile */
TOP   := tb_sobel_edge
FLIST := sobel_edge_top.f

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module sobel_edge_top -f $(FLIST)

clean:
	rm -rf obj_dir
